/* src/l2_pkg.sv */
// L2 cache shared definitions
// Cache dimensions, request codes and the two decodings of a line address
package l2_pkg;

	// L2 organization, 4 ways by 16 sets of one word each
	localparam int num_ways = 4;
	localparam int way_width = 2;
	localparam int l2_set_width = 4;
	localparam int l2_tag_width = 12;
	localparam int l2_num_sets = 1 << l2_set_width;

	// Cores and their L1 data caches
	// The L1 caches are 4-way as well, so an L1 way index is way_width bits wide
	localparam int num_cores = 2;
	localparam int core_width = 1;
	localparam int l1_set_width = 3;
	localparam int l1_tag_width = 13;
	localparam int l1_num_sets = 1 << l1_set_width;

	// Line geometry
	localparam int line_addr_width = 16;
	localparam int data_width = 32;
	localparam int mask_width = 4;

	// Request operations
	typedef enum logic [1:0]
	{
		op_load = 2'd0,
		op_store = 2'd1,
		op_flush = 2'd2,
		op_dinvalidate = 2'd3
	} op_t;

	// Requesting unit within a core
	typedef enum logic
	{
		unit_dcache = 1'b0,
		unit_icache = 1'b1
	} unit_t;

	// A line address splits differently for the L2 and for the L1 directory
	typedef union packed
	{
		struct packed
		{
			logic [l2_tag_width-1:0] tag;
			logic [l2_set_width-1:0] set;
		} l2;
		struct packed
		{
			logic [l1_tag_width-1:0] tag;
			logic [l1_set_width-1:0] set;
		} l1;
	} line_addr_t;

endpackage

/* src/l2_tag_stage.sv */
`timescale 1ns/1ps
// L2 cache tag stage
// Reads the tag, valid and dirty arrays and the L1 directory for a new request,
// picks a fill victim and applies the updates coming back from the directory stage
module l2_tag_stage(
	input  logic clk,
	input  logic reset,
	input  logic stall_pipeline,
	input  logic req_valid,
	input  logic [l2_pkg::core_width-1:0] req_core,
	input  l2_pkg::unit_t req_unit,
	input  l2_pkg::op_t req_op,
	input  logic [l2_pkg::way_width-1:0] req_l1_way,
	input  l2_pkg::line_addr_t req_address,
	input  logic [l2_pkg::data_width-1:0] req_data,
	input  logic [l2_pkg::mask_width-1:0] req_mask,
	input  logic req_restarted,
	input  logic [l2_pkg::data_width-1:0] req_fill_data,
	input  logic update_tag_enable,
	input  logic update_tag_valid,
	input  logic [l2_pkg::way_width-1:0] update_tag_way,
	input  logic [l2_pkg::l2_set_width-1:0] update_tag_set,
	input  logic [l2_pkg::l2_tag_width-1:0] update_tag_tag,
	input  logic [l2_pkg::num_ways-1:0] update_dirty,
	input  logic [l2_pkg::l2_set_width-1:0] update_dirty_set,
	input  logic new_dirty,
	input  logic update_directory,
	input  logic [l2_pkg::core_width-1:0] update_dir_core,
	input  logic [l2_pkg::l1_set_width-1:0] update_dir_set,
	input  logic [l2_pkg::way_width-1:0] update_dir_way,
	input  logic [l2_pkg::l1_tag_width-1:0] update_dir_tag,
	input  logic update_dir_valid,
	output logic tag_valid,
	output logic [l2_pkg::core_width-1:0] tag_core,
	output l2_pkg::unit_t tag_unit,
	output l2_pkg::op_t tag_op,
	output logic [l2_pkg::way_width-1:0] tag_req_l1_way,
	output l2_pkg::line_addr_t tag_address,
	output logic [l2_pkg::data_width-1:0] tag_data,
	output logic [l2_pkg::mask_width-1:0] tag_mask,
	output logic tag_restarted,
	output logic [l2_pkg::data_width-1:0] tag_fill_data,
	output logic [l2_pkg::num_ways-1:0][l2_pkg::l2_tag_width-1:0] tag_tags,
	output logic [l2_pkg::num_ways-1:0] tag_valids,
	output logic [l2_pkg::num_ways-1:0] tag_dirties,
	output logic [l2_pkg::way_width-1:0] tag_victim_way,
	output logic [l2_pkg::num_cores-1:0] tag_l1_has_line,
	output logic [l2_pkg::num_cores-1:0][l2_pkg::way_width-1:0] tag_l1_way);

	// L2 state, one row of ways per set
	logic [l2_pkg::num_ways-1:0][l2_pkg::l2_tag_width-1:0] tag_mem [l2_pkg::l2_num_sets];
	logic [l2_pkg::num_ways-1:0] valid_mem [l2_pkg::l2_num_sets];
	logic [l2_pkg::num_ways-1:0] dirty_mem [l2_pkg::l2_num_sets];
	logic [l2_pkg::way_width-1:0] rr_ptr [l2_pkg::l2_num_sets];

	// L1 directory, a copy of each core's L1 data cache tags
	logic [l2_pkg::num_ways-1:0] l1_valid_mem [l2_pkg::num_cores][l2_pkg::l1_num_sets];
	logic [l2_pkg::num_ways-1:0][l2_pkg::l1_tag_width-1:0]
		l1_tag_mem [l2_pkg::num_cores][l2_pkg::l1_num_sets];

	logic [l2_pkg::l2_set_width-1:0] l2_set;
	logic [l2_pkg::l1_set_width-1:0] l1_set;
	logic [l2_pkg::num_ways-1:0][l2_pkg::l2_tag_width-1:0] fwd_tags;
	logic [l2_pkg::num_ways-1:0] fwd_valids;
	logic [l2_pkg::num_ways-1:0] fwd_dirties;
	logic [l2_pkg::way_width-1:0] fwd_rr_ptr;
	logic [l2_pkg::way_width-1:0] victim_way;
	logic [l2_pkg::num_cores-1:0] l1_has_line;
	logic [l2_pkg::num_cores-1:0][l2_pkg::way_width-1:0] l1_way;

	assign l2_set = req_address.l2.set;
	assign l1_set = req_address.l1.set;

	// Read the L2 row, bypassing any update written at the coming edge
	always_comb
	begin
		fwd_tags = tag_mem[l2_set];
		fwd_valids = valid_mem[l2_set];
		fwd_rr_ptr = rr_ptr[l2_set];
		fwd_dirties = dirty_mem[l2_set];
		if (update_tag_enable && update_tag_set == l2_set)
		begin
			fwd_tags[update_tag_way] = update_tag_tag;
			fwd_valids[update_tag_way] = update_tag_valid;
			if (update_tag_valid)
				fwd_rr_ptr = fwd_rr_ptr + 1'b1;
		end
		if (update_dirty_set == l2_set)
			fwd_dirties = (fwd_dirties & ~update_dirty) | (update_dirty & {l2_pkg::num_ways{new_dirty}});
	end

	// Lowest invalid way wins, otherwise the set's round-robin pointer
	always_comb
	begin
		victim_way = fwd_rr_ptr;
		for (int w = l2_pkg::num_ways - 1; w >= 0; w--)
			if (!fwd_valids[w])
				victim_way = l2_pkg::way_width'(w);
	end

	// Look the line up in every core's directory row, again with bypass
	always_comb
	begin
		logic [l2_pkg::num_ways-1:0] row_valid;
		logic [l2_pkg::num_ways-1:0][l2_pkg::l1_tag_width-1:0] row_tag;
		for (int c = 0; c < l2_pkg::num_cores; c++)
		begin
			row_valid = l1_valid_mem[c][l1_set];
			row_tag = l1_tag_mem[c][l1_set];
			if (update_directory && update_dir_core == l2_pkg::core_width'(c)
				&& update_dir_set == l1_set)
			begin
				row_valid[update_dir_way] = update_dir_valid;
				row_tag[update_dir_way] = update_dir_tag;
			end
			l1_has_line[c] = 1'b0;
			l1_way[c] = '0;
			for (int w = 0; w < l2_pkg::num_ways; w++)
			begin
				if (row_valid[w] && row_tag[w] == req_address.l1.tag)
				begin
					l1_has_line[c] = 1'b1;
					l1_way[c] = l2_pkg::way_width'(w);
				end
			end
		end
	end

	// Control state of the arrays
	// The update enables already carry the stall, so no extra gating here
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < l2_pkg::l2_num_sets; s++)
			begin
				valid_mem[s] <= '0;
				rr_ptr[s] <= '0;
			end
			for (int c = 0; c < l2_pkg::num_cores; c++)
				for (int s = 0; s < l2_pkg::l1_num_sets; s++)
					l1_valid_mem[c][s] <= '0;
		end
		else
		begin
			if (update_tag_enable)
			begin
				valid_mem[update_tag_set][update_tag_way] <= update_tag_valid;
				if (update_tag_valid)
					rr_ptr[update_tag_set] <= rr_ptr[update_tag_set] + 1'b1;
			end
			if (update_directory)
				l1_valid_mem[update_dir_core][update_dir_set][update_dir_way] <= update_dir_valid;
		end
	end

	// Tag and dirty payload, only meaningful where the valid bit is set
	always_ff @(posedge clk)
	begin
		if (update_tag_enable)
			tag_mem[update_tag_set][update_tag_way] <= update_tag_tag;
		for (int w = 0; w < l2_pkg::num_ways; w++)
			if (update_dirty[w])
				dirty_mem[update_dirty_set][w] <= new_dirty;
		if (update_directory)
			l1_tag_mem[update_dir_core][update_dir_set][update_dir_way] <= update_dir_tag;
	end

	// Stage register
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			tag_valid <= 1'b0;
		else if (!stall_pipeline)
			tag_valid <= req_valid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall_pipeline)
		begin
			tag_core <= req_core;
			tag_unit <= req_unit;
			tag_op <= req_op;
			tag_req_l1_way <= req_l1_way;
			tag_address <= req_address;
			tag_data <= req_data;
			tag_mask <= req_mask;
			tag_restarted <= req_restarted;
			tag_fill_data <= req_fill_data;
			tag_tags <= fwd_tags;
			tag_valids <= fwd_valids;
			tag_dirties <= fwd_dirties;
			tag_victim_way <= victim_way;
			tag_l1_has_line <= l1_has_line;
			tag_l1_way <= l1_way;
		end
	end

endmodule

/* src/l2_dir_stage.sv */
`timescale 1ns/1ps
// L2 cache directory stage
// Resolves hit, fill and victim from the tag lookup, drives tag, dirty and
// L1 directory updates back into the tag stage and raises hit and miss events
module l2_dir_stage(
	input  logic clk,
	input  logic reset,
	input  logic stall_pipeline,
	input  logic tag_valid,
	input  logic [l2_pkg::core_width-1:0] tag_core,
	input  l2_pkg::unit_t tag_unit,
	input  l2_pkg::op_t tag_op,
	input  logic [l2_pkg::way_width-1:0] tag_req_l1_way,
	input  l2_pkg::line_addr_t tag_address,
	input  logic [l2_pkg::data_width-1:0] tag_data,
	input  logic [l2_pkg::mask_width-1:0] tag_mask,
	input  logic tag_restarted,
	input  logic [l2_pkg::data_width-1:0] tag_fill_data,
	input  logic [l2_pkg::num_ways-1:0][l2_pkg::l2_tag_width-1:0] tag_tags,
	input  logic [l2_pkg::num_ways-1:0] tag_valids,
	input  logic [l2_pkg::num_ways-1:0] tag_dirties,
	input  logic [l2_pkg::way_width-1:0] tag_victim_way,
	input  logic [l2_pkg::num_cores-1:0] tag_l1_has_line,
	input  logic [l2_pkg::num_cores-1:0][l2_pkg::way_width-1:0] tag_l1_way,
	output logic dir_valid,
	output logic [l2_pkg::core_width-1:0] dir_core,
	output l2_pkg::unit_t dir_unit,
	output l2_pkg::op_t dir_op,
	output l2_pkg::line_addr_t dir_address,
	output logic [l2_pkg::data_width-1:0] dir_data,
	output logic [l2_pkg::mask_width-1:0] dir_mask,
	output logic [l2_pkg::data_width-1:0] dir_fill_data,
	output logic dir_is_fill,
	output logic dir_cache_hit,
	output logic [l2_pkg::way_width-1:0] dir_hit_way,
	output logic [l2_pkg::way_width-1:0] dir_fill_way,
	output logic [l2_pkg::l2_tag_width-1:0] dir_old_tag,
	output logic [l2_pkg::num_ways-1:0] dir_dirties,
	output logic update_tag_enable,
	output logic update_tag_valid,
	output logic [l2_pkg::way_width-1:0] update_tag_way,
	output logic [l2_pkg::l2_set_width-1:0] update_tag_set,
	output logic [l2_pkg::l2_tag_width-1:0] update_tag_tag,
	output logic [l2_pkg::num_ways-1:0] update_dirty,
	output logic [l2_pkg::l2_set_width-1:0] update_dirty_set,
	output logic new_dirty,
	output logic update_directory,
	output logic [l2_pkg::core_width-1:0] update_dir_core,
	output logic [l2_pkg::l1_set_width-1:0] update_dir_set,
	output logic [l2_pkg::way_width-1:0] update_dir_way,
	output logic [l2_pkg::l1_tag_width-1:0] update_dir_tag,
	output logic update_dir_valid,
	output logic event_hit,
	output logic event_miss);

	logic [l2_pkg::num_ways-1:0] way_hit;
	logic [l2_pkg::way_width-1:0] hit_way;
	logic [l2_pkg::way_width-1:0] target_way;
	logic cache_hit, is_fill, advance;
	logic is_load, is_store, is_flush, is_invalidate;

	assign is_load = tag_op == l2_pkg::op_load;
	assign is_store = tag_op == l2_pkg::op_store;
	assign is_flush = tag_op == l2_pkg::op_flush;
	assign is_invalidate = tag_op == l2_pkg::op_dinvalidate;

	// Compare the request tag against every valid way
	// At most one way can match, so the encoder just keeps the last match
	always_comb
	begin
		hit_way = '0;
		for (int w = 0; w < l2_pkg::num_ways; w++)
		begin
			way_hit[w] = tag_valids[w] && tag_tags[w] == tag_address.l2.tag;
			if (way_hit[w])
				hit_way = l2_pkg::way_width'(w);
		end
	end

	assign cache_hit = |way_hit;

	// A full-mask store miss overwrites the whole line, so there is nothing to fetch
	assign is_fill = tag_restarted || (is_store && tag_mask == '1 && !cache_hit);

	// Fills land in the victim way and everything else works on the hit way
	assign target_way = is_fill ? tag_victim_way : hit_way;

	// Updates are only issued when the request really moves on at this edge
	assign advance = tag_valid && !stall_pipeline;

	// Tags are written by fills and cleared by invalidates that hit
	assign update_tag_enable = advance && (is_fill || (is_invalidate && cache_hit));
	assign update_tag_valid = !is_invalidate;
	assign update_tag_way = target_way;
	assign update_tag_set = tag_address.l2.set;
	assign update_tag_tag = tag_address.l2.tag;

	// Dirty bits, a fill is dirty only when it carries store data
	assign update_dirty = (advance && (is_fill || (cache_hit && (is_store || is_flush))))
		? l2_pkg::num_ways'(1) << target_way : '0;
	assign update_dirty_set = tag_address.l2.set;
	assign new_dirty = is_fill ? is_store : !is_flush;

	// The L1 data cache receives the line on a load, so record it in the directory
	// An invalidate drops the entry only from the requesting core
	assign update_directory = advance && ((is_load && tag_unit == l2_pkg::unit_dcache
		&& (cache_hit || is_fill)) || (is_invalidate && tag_l1_has_line[tag_core]));
	assign update_dir_core = tag_core;
	assign update_dir_set = tag_address.l1.set;
	assign update_dir_way = is_invalidate ? tag_l1_way[tag_core] : tag_req_l1_way;
	assign update_dir_tag = tag_address.l1.tag;
	assign update_dir_valid = !is_invalidate;

	// Only the first pass of a load or store is counted
	// A full-mask store miss still counts as a miss
	assign event_hit = advance && !tag_restarted && (is_load || is_store) && cache_hit;
	assign event_miss = advance && !tag_restarted && (is_load || is_store) && !cache_hit;

	// Stage register
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			dir_valid <= 1'b0;
		else if (!stall_pipeline)
			dir_valid <= tag_valid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall_pipeline)
		begin
			dir_core <= tag_core;
			dir_unit <= tag_unit;
			dir_op <= tag_op;
			dir_address <= tag_address;
			dir_data <= tag_data;
			dir_mask <= tag_mask;
			dir_fill_data <= tag_fill_data;
			dir_is_fill <= is_fill;
			dir_cache_hit <= cache_hit;
			dir_hit_way <= hit_way;
			dir_fill_way <= tag_victim_way;
			// Tag of whatever occupies the target way, used to rebuild a writeback
			dir_old_tag <= tag_tags[target_way];
			dir_dirties <= tag_dirties & tag_valids;
		end
	end

endmodule

/* src/l2_read_stage.sv */
`timescale 1ns/1ps
// L2 cache read stage
// Reads and updates the data array, builds the response with any dirty
// writeback and counts hit and miss events
module l2_read_stage(
	input  logic clk,
	input  logic reset,
	input  logic stall_pipeline,
	input  logic dir_valid,
	input  logic [l2_pkg::core_width-1:0] dir_core,
	input  l2_pkg::unit_t dir_unit,
	input  l2_pkg::op_t dir_op,
	input  l2_pkg::line_addr_t dir_address,
	input  logic [l2_pkg::data_width-1:0] dir_data,
	input  logic [l2_pkg::mask_width-1:0] dir_mask,
	input  logic [l2_pkg::data_width-1:0] dir_fill_data,
	input  logic dir_is_fill,
	input  logic dir_cache_hit,
	input  logic [l2_pkg::way_width-1:0] dir_hit_way,
	input  logic [l2_pkg::way_width-1:0] dir_fill_way,
	input  logic [l2_pkg::l2_tag_width-1:0] dir_old_tag,
	input  logic [l2_pkg::num_ways-1:0] dir_dirties,
	input  logic event_hit,
	input  logic event_miss,
	output logic resp_valid,
	output logic [l2_pkg::core_width-1:0] resp_core,
	output l2_pkg::unit_t resp_unit,
	output l2_pkg::op_t resp_op,
	output l2_pkg::line_addr_t resp_address,
	output logic resp_hit,
	output logic resp_miss,
	output logic [l2_pkg::data_width-1:0] resp_data,
	output logic resp_writeback,
	output l2_pkg::line_addr_t resp_wb_address,
	output logic [l2_pkg::data_width-1:0] resp_wb_data,
	output logic [15:0] perf_hits,
	output logic [15:0] perf_misses);

	logic [l2_pkg::data_width-1:0] data_mem [l2_pkg::l2_num_sets][l2_pkg::num_ways];
	logic [l2_pkg::way_width-1:0] line_way;
	logic [l2_pkg::data_width-1:0] old_line, new_line;
	logic is_store, write_line;

	// Replace the bytes of base selected by mask with those of bytes
	function automatic logic [l2_pkg::data_width-1:0] merge_bytes(
		input logic [l2_pkg::data_width-1:0] base,
		input logic [l2_pkg::data_width-1:0] bytes,
		input logic [l2_pkg::mask_width-1:0] mask);
		logic [l2_pkg::data_width-1:0] result;
		result = base;
		for (int b = 0; b < l2_pkg::mask_width; b++)
			if (mask[b])
				result[b * 8 +: 8] = bytes[b * 8 +: 8];
		return result;
	endfunction

	assign is_store = dir_op == l2_pkg::op_store;
	assign line_way = dir_is_fill ? dir_fill_way : dir_hit_way;

	// Old contents of the addressed way, which is also the writeback data
	assign old_line = data_mem[dir_address.l2.set][line_way];

	// A fill takes the memory word with any store bytes laid on top
	always_comb
	begin
		if (dir_is_fill)
			new_line = merge_bytes(dir_fill_data, dir_data, dir_mask & {l2_pkg::mask_width{is_store}});
		else if (is_store && dir_cache_hit)
			new_line = merge_bytes(old_line, dir_data, dir_mask);
		else
			new_line = old_line;
	end

	assign write_line = dir_valid && !stall_pipeline && (dir_is_fill || (is_store && dir_cache_hit));

	always_ff @(posedge clk)
	begin
		if (write_line)
			data_mem[dir_address.l2.set][line_way] <= new_line;
	end

	// Response register, which holds while the consumer is not ready
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			resp_valid <= 1'b0;
		else if (!stall_pipeline)
			resp_valid <= dir_valid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall_pipeline)
		begin
			resp_core <= dir_core;
			resp_unit <= dir_unit;
			resp_op <= dir_op;
			resp_address <= dir_address;
			resp_hit <= dir_cache_hit || dir_is_fill;
			resp_miss <= (dir_op == l2_pkg::op_load || is_store) && !dir_cache_hit && !dir_is_fill;
			resp_data <= new_line;
			// Evicting a dirty line hands the old word back to memory
			resp_writeback <= dir_is_fill && dir_dirties[dir_fill_way];
			resp_wb_address <= {dir_old_tag, dir_address.l2.set};
			resp_wb_data <= old_line;
		end
	end

	// Event counters, the events already carry the stall
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			perf_hits <= '0;
			perf_misses <= '0;
		end
		else
		begin
			if (event_hit)
				perf_hits <= perf_hits + 1'b1;
			if (event_miss)
				perf_misses <= perf_misses + 1'b1;
		end
	end

endmodule

/* src/l2_cache.sv */
`timescale 1ns/1ps
// Shared L2 cache
// Three-stage pipeline of tag lookup, directory resolution and data read,
// stalled as a whole while a response waits for the consumer
module l2_cache(
	input  logic clk,
	input  logic reset,
	input  logic req_valid,
	input  logic [l2_pkg::core_width-1:0] req_core,
	input  l2_pkg::unit_t req_unit,
	input  l2_pkg::op_t req_op,
	input  logic [l2_pkg::way_width-1:0] req_l1_way,
	input  l2_pkg::line_addr_t req_address,
	input  logic [l2_pkg::data_width-1:0] req_data,
	input  logic [l2_pkg::mask_width-1:0] req_mask,
	input  logic req_restarted,
	input  logic [l2_pkg::data_width-1:0] req_fill_data,
	output logic req_ready,
	output logic resp_valid,
	output logic [l2_pkg::core_width-1:0] resp_core,
	output l2_pkg::unit_t resp_unit,
	output l2_pkg::op_t resp_op,
	output l2_pkg::line_addr_t resp_address,
	output logic resp_hit,
	output logic resp_miss,
	output logic [l2_pkg::data_width-1:0] resp_data,
	output logic resp_writeback,
	output l2_pkg::line_addr_t resp_wb_address,
	output logic [l2_pkg::data_width-1:0] resp_wb_data,
	input  logic resp_ready,
	output logic [15:0] perf_hits,
	output logic [15:0] perf_misses);

	logic stall_pipeline;

	// Tag stage to directory stage
	logic tag_valid, tag_restarted;
	logic [l2_pkg::core_width-1:0] tag_core;
	l2_pkg::unit_t tag_unit;
	l2_pkg::op_t tag_op;
	logic [l2_pkg::way_width-1:0] tag_req_l1_way, tag_victim_way;
	l2_pkg::line_addr_t tag_address;
	logic [l2_pkg::data_width-1:0] tag_data, tag_fill_data;
	logic [l2_pkg::mask_width-1:0] tag_mask;
	logic [l2_pkg::num_ways-1:0][l2_pkg::l2_tag_width-1:0] tag_tags;
	logic [l2_pkg::num_ways-1:0] tag_valids, tag_dirties;
	logic [l2_pkg::num_cores-1:0] tag_l1_has_line;
	logic [l2_pkg::num_cores-1:0][l2_pkg::way_width-1:0] tag_l1_way;

	// Directory stage back into the tag stage
	logic update_tag_enable, update_tag_valid, new_dirty;
	logic update_directory, update_dir_valid;
	logic [l2_pkg::way_width-1:0] update_tag_way, update_dir_way;
	logic [l2_pkg::l2_set_width-1:0] update_tag_set, update_dirty_set;
	logic [l2_pkg::l2_tag_width-1:0] update_tag_tag;
	logic [l2_pkg::num_ways-1:0] update_dirty;
	logic [l2_pkg::core_width-1:0] update_dir_core;
	logic [l2_pkg::l1_set_width-1:0] update_dir_set;
	logic [l2_pkg::l1_tag_width-1:0] update_dir_tag;

	// Directory stage to read stage
	logic dir_valid, dir_is_fill, dir_cache_hit, event_hit, event_miss;
	logic [l2_pkg::core_width-1:0] dir_core;
	l2_pkg::unit_t dir_unit;
	l2_pkg::op_t dir_op;
	l2_pkg::line_addr_t dir_address;
	logic [l2_pkg::data_width-1:0] dir_data, dir_fill_data;
	logic [l2_pkg::mask_width-1:0] dir_mask;
	logic [l2_pkg::way_width-1:0] dir_hit_way, dir_fill_way;
	logic [l2_pkg::l2_tag_width-1:0] dir_old_tag;
	logic [l2_pkg::num_ways-1:0] dir_dirties;

	// A response nobody takes freezes every stage, so nothing is lost in flight
	assign stall_pipeline = resp_valid && !resp_ready;
	assign req_ready = !stall_pipeline;

	l2_tag_stage tag_stage(.*);
	l2_dir_stage dir_stage(.*);
	l2_read_stage read_stage(.*);

endmodule

/* tb/l2_cache_checks.svh */
// L2 cache testbench checks
// Typed compare tasks for the cache responses and the error counters they feed
`ifndef L2_CACHE_CHECKS_SVH
`define L2_CACHE_CHECKS_SVH

int checks_done = 0;
int mismatches = 0;
int protocol_errors = 0;

// Single-bit response fields such as hit, miss and writeback
task automatic check_flag(input string name, input logic actual, input logic reference);
	checks_done++;
	if (actual !== reference)
	begin
		mismatches++;
		$display("ERROR %s: got %h, expected %h at %0t", name, actual, reference, $time);
	end
endtask

task automatic check_data(input string name, input logic [l2_pkg::data_width-1:0] actual,
	input logic [l2_pkg::data_width-1:0] reference);
	checks_done++;
	if (actual !== reference)
	begin
		mismatches++;
		$display("ERROR %s: got %h, expected %h at %0t", name, actual, reference, $time);
	end
endtask

task automatic check_address(input string name, input l2_pkg::line_addr_t actual,
	input l2_pkg::line_addr_t reference);
	checks_done++;
	if (actual !== reference)
	begin
		mismatches++;
		$display("ERROR %s: got %h, expected %h at %0t", name, actual, reference, $time);
	end
endtask

// The operation code echoed back with the response
task automatic check_op(input string name, input l2_pkg::op_t actual,
	input l2_pkg::op_t reference);
	checks_done++;
	if (actual !== reference)
	begin
		mismatches++;
		$display("ERROR %s: got %h, expected %h at %0t", name, actual, reference, $time);
	end
endtask

task automatic check_unit(input string name, input l2_pkg::unit_t actual,
	input l2_pkg::unit_t reference);
	checks_done++;
	if (actual !== reference)
	begin
		mismatches++;
		$display("ERROR %s: got %h, expected %h at %0t", name, actual, reference, $time);
	end
endtask

// Event counters are 16 bits wide
task automatic check_count(input string name, input logic [15:0] actual,
	input logic [15:0] reference);
	checks_done++;
	if (actual !== reference)
	begin
		mismatches++;
		$display("ERROR %s: got %h, expected %h at %0t", name, actual, reference, $time);
	end
endtask

task automatic report_protocol_error(input string what);
	protocol_errors++;
	$display("Protocol error at %0t: %s", $time, what);
endtask

task automatic print_error_counts();
	$display("Checks %0d, value mismatches %0d, protocol errors %0d",
		checks_done, mismatches, protocol_errors);
endtask

`endif

/* tb/l2_cache_tb.sv */
`timescale 1ns/1ps
// L2 cache testbench
// Streams the request vectors into the cache under random response back-pressure
// and checks each response in order, then the hit and miss counters
module l2_cache_tb;

	// One request together with the response it should produce
	typedef struct packed
	{
		logic [l2_pkg::core_width-1:0] core;
		l2_pkg::unit_t unit;
		l2_pkg::op_t op;
		logic [l2_pkg::way_width-1:0] l1_way;
		l2_pkg::line_addr_t address;
		logic [l2_pkg::data_width-1:0] data;
		logic [l2_pkg::mask_width-1:0] mask;
		logic restarted;
		logic [l2_pkg::data_width-1:0] fill_data;
		logic hit;
		logic miss;
		logic [l2_pkg::data_width-1:0] line_data;
		logic writeback;
		l2_pkg::line_addr_t wb_address;
		logic [l2_pkg::data_width-1:0] wb_data;
		logic [1:0] event_kind;
	} vector_t;

	logic clk, reset;
	logic req_valid, req_restarted, req_ready, resp_ready;
	logic [l2_pkg::core_width-1:0] req_core, resp_core;
	l2_pkg::unit_t req_unit, resp_unit;
	l2_pkg::op_t req_op, resp_op;
	logic [l2_pkg::way_width-1:0] req_l1_way;
	l2_pkg::line_addr_t req_address, resp_address, resp_wb_address;
	logic [l2_pkg::data_width-1:0] req_data, req_fill_data, resp_data, resp_wb_data;
	logic [l2_pkg::mask_width-1:0] req_mask;
	logic resp_valid, resp_hit, resp_miss, resp_writeback;
	logic [15:0] perf_hits, perf_misses;

	vector_t vectors[$];
	vector_t pending[$];
	int accepted = 0;
	int responses = 0;
	int cycles = 0;
	int timeout_limit = 100;
	logic [15:0] hits_expected = '0;
	logic [15:0] misses_expected = '0;

	`include "l2_cache_checks.svh"

	l2_cache uut(.*);

	always #5 clk = ~clk;

	// Load every request line and skip lines that do not parse as one
	task automatic read_vectors();
		int fd, fields;
		string line;
		logic [31:0] f [16];
		vector_t v;
		fd = $fopen("tb/l2_cache_vectors.txt", "r");
		if (fd == 0)
			report_protocol_error("could not open the vector file");
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
					f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
				if (fields == 16)
				begin
					v.core = f[0][l2_pkg::core_width-1:0];
					v.unit = l2_pkg::unit_t'(f[1][0]);
					v.op = l2_pkg::op_t'(f[2][1:0]);
					v.l1_way = f[3][l2_pkg::way_width-1:0];
					v.address = f[4][l2_pkg::line_addr_width-1:0];
					v.data = f[5];
					v.mask = f[6][l2_pkg::mask_width-1:0];
					v.restarted = f[7][0];
					v.fill_data = f[8];
					v.hit = f[9][0];
					v.miss = f[10][0];
					v.line_data = f[11];
					v.writeback = f[12][0];
					v.wb_address = f[13][l2_pkg::line_addr_width-1:0];
					v.wb_data = f[14];
					v.event_kind = f[15][1:0];
					// Kind 1 is a counted hit and kind 2 a counted miss
					hits_expected += (v.event_kind == 2'd1);
					misses_expected += (v.event_kind == 2'd2);
					vectors.push_back(v);
				end
			end
			$fclose(fd);
			if (vectors.size() == 0)
				report_protocol_error("the vector file holds no requests");
		end
	endtask

	task automatic drive_request(input vector_t v);
		req_valid <= 1'b1;
		req_core <= v.core;
		req_unit <= v.unit;
		req_op <= v.op;
		req_l1_way <= v.l1_way;
		req_address <= v.address;
		req_data <= v.data;
		req_mask <= v.mask;
		req_restarted <= v.restarted;
		req_fill_data <= v.fill_data;
	endtask

	// Data is only defined when the line is present and writeback fields only on a writeback
	task automatic compare_response(input vector_t v);
		check_address("resp_address", resp_address, v.address);
		check_flag("resp_core", resp_core, v.core);
		check_unit("resp_unit", resp_unit, v.unit);
		check_op("resp_op", resp_op, v.op);
		check_flag("resp_hit", resp_hit, v.hit);
		check_flag("resp_miss", resp_miss, v.miss);
		check_flag("resp_writeback", resp_writeback, v.writeback);
		if (v.hit)
			check_data("resp_data", resp_data, v.line_data);
		if (v.writeback)
		begin
			check_address("resp_wb_address", resp_wb_address, v.wb_address);
			check_data("resp_wb_data", resp_wb_data, v.wb_data);
		end
	endtask

	// The consumer refuses about one response in four
	always @(posedge clk)
	begin
		if (!reset)
			resp_ready <= ($urandom % 4) != 0;
	end

	// Responses are taken in acceptance order
	always @(posedge clk)
	begin
		if (resp_valid && resp_ready)
		begin
			if (pending.size() == 0)
				report_protocol_error("a response arrived with no request outstanding");
			else
				compare_response(pending.pop_front());
			responses <= responses + 1;
		end
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= timeout_limit)
		begin
			$display("Timeout after %0d cycles, %0d of %0d responses received",
				cycles, responses, vectors.size());
			print_error_counts();
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial
	begin
		// Seed the back-pressure pattern once for the whole run
		void'($urandom(32'h8b60_772d));
		clk = 1'b0;
		reset = 1'b1;
		req_valid = 1'b0;
		req_core = '0;
		req_unit = l2_pkg::unit_dcache;
		req_op = l2_pkg::op_load;
		req_l1_way = '0;
		req_address = '0;
		req_data = '0;
		req_mask = '0;
		req_restarted = 1'b0;
		req_fill_data = '0;
		resp_ready = 1'b1;
		read_vectors();
		timeout_limit = vectors.size() * 20 + 100;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		while (accepted < vectors.size())
		begin
			drive_request(vectors[accepted]);
			@(posedge clk);
			// The request stays on the bus until the cache takes it
			if (req_ready)
			begin
				pending.push_back(vectors[accepted]);
				accepted++;
			end
		end
		req_valid <= 1'b0;
		while (responses < vectors.size())
			@(posedge clk);
		repeat (2) @(posedge clk);
		check_count("perf_hits", perf_hits, hits_expected);
		check_count("perf_misses", perf_misses, misses_expected);
		if (pending.size() != 0)
			report_protocol_error("requests were left without a response");
		print_error_counts();
		if (mismatches == 0 && protocol_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* tb/l2_cache_vectors.txt */
# core unit op l1way addr data mask restarted fill | hit miss line wb wbaddr wbdata event
# op 0 load 1 store 2 flush 3 dinvalidate, event 1 counted hit 2 counted miss
# load miss, restart fills way 0, then hits
0 0 0 0 0011 00000000 0 0 00000000 0 1 00000000 0 0000 00000000 2
0 0 0 0 0011 00000000 0 1 11112222 1 0 11112222 0 0000 00000000 0
0 0 0 1 0011 00000000 0 0 00000000 1 0 11112222 0 0000 00000000 1
# masked store hits back to back
0 0 1 0 0011 aabbccdd 3 0 00000000 1 0 1111ccdd 0 0000 00000000 1
1 0 1 0 0011 99887766 8 0 00000000 1 0 9911ccdd 0 0000 00000000 1
1 0 0 2 0011 00000000 0 0 00000000 1 0 9911ccdd 0 0000 00000000 1
# full-mask store miss fills way 1 without a restart
0 0 1 0 0021 12345678 f 0 00000000 1 0 12345678 0 0000 00000000 2
0 0 0 0 0021 00000000 0 0 00000000 1 0 12345678 0 0000 00000000 1
# fill ways 2 and 3, then round robin from way 0 evicts the dirty line
0 0 0 0 0031 00000000 0 1 33333333 1 0 33333333 0 0000 00000000 0
0 0 0 0 0041 00000000 0 1 44444444 1 0 44444444 0 0000 00000000 0
0 0 0 0 0051 00000000 0 1 55555555 1 0 55555555 1 0011 9911ccdd 0
# flush cleans way 1 just before it is replaced
0 0 2 0 0021 00000000 0 0 00000000 1 0 12345678 0 0000 00000000 0
0 0 0 0 0061 00000000 0 1 66666666 1 0 66666666 0 0000 00000000 0
0 0 1 0 0071 000000ab 1 1 77777777 1 0 777777ab 0 0000 00000000 0
0 0 0 0 0081 00000000 0 1 88888888 1 0 88888888 0 0000 00000000 0
0 0 0 0 0091 00000000 0 1 99999999 1 0 99999999 0 0000 00000000 0
0 0 0 0 00a1 00000000 0 1 aaaaaaaa 1 0 aaaaaaaa 0 0000 00000000 0
0 0 0 0 00b1 00000000 0 1 bbbbbbbb 1 0 bbbbbbbb 1 0071 777777ab 0
# invalidate hits remove the line in set 2
0 0 1 0 0102 cafef00d f 0 00000000 1 0 cafef00d 0 0000 00000000 2
0 0 3 0 0102 00000000 0 0 00000000 1 0 cafef00d 0 0000 00000000 0
0 0 0 1 0102 00000000 0 0 00000000 0 1 00000000 0 0000 00000000 2
0 0 0 1 0102 00000000 0 1 0badbeef 1 0 0badbeef 0 0000 00000000 0
0 0 0 1 0102 00000000 0 0 00000000 1 0 0badbeef 0 0000 00000000 1
1 0 3 0 0102 00000000 0 0 00000000 1 0 0badbeef 0 0000 00000000 0
0 0 0 0 0102 00000000 0 0 00000000 0 1 00000000 0 0000 00000000 2
# second core in set 3, partial store miss and flush miss
1 1 0 0 0203 00000000 0 0 00000000 0 1 00000000 0 0000 00000000 2
1 1 0 0 0203 00000000 0 1 01234567 1 0 01234567 0 0000 00000000 0
1 0 1 0 0203 ffee0000 c 0 00000000 1 0 ffee4567 0 0000 00000000 1
1 0 1 0 0303 00000011 1 0 00000000 0 1 00000000 0 0000 00000000 2
1 0 2 0 0403 00000000 0 0 00000000 0 0 00000000 0 0000 00000000 0
1 1 0 0 0203 00000000 0 0 00000000 1 0 ffee4567 0 0000 00000000 1
# final state of set 1
0 0 0 0 00b1 00000000 0 0 00000000 1 0 bbbbbbbb 0 0000 00000000 1
0 0 0 0 0071 00000000 0 0 00000000 0 1 00000000 0 0000 00000000 2
0 0 0 0 0011 00000000 0 0 00000000 0 1 00000000 0 0000 00000000 2

/* src.f */
+incdir+tb
src/l2_pkg.sv
src/l2_tag_stage.sv
src/l2_dir_stage.sv
src/l2_read_stage.sv
src/l2_cache.sv
tb/l2_cache_tb.sv

/* Bender.yml */
package:
  name: l2_cache

sources:
  - files:
      - src/l2_pkg.sv
      - src/l2_tag_stage.sv
      - src/l2_dir_stage.sv
      - src/l2_read_stage.sv
      - src/l2_cache.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/l2_cache_tb.sv
